//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := trace_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

# Status comes from the search for the pass line, not from the simulator
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/async_fifo.sv
`timescale 1ns/1ps
`include "trace_config.svh"

module async_fifo import trace_pkg::*; (
   input  logic wclk,
   input  logic wrst_n,
   input  logic rclk,
   input  logic rrst_n,
   input  rec_t din,
   input  logic push,
   input  logic pop,
   output rec_t dout,
   output logic full,
   output logic empty
);

   localparam int AW    = `TRACE_AW;
   localparam int DEPTH = 1 << AW;

   // Top two bits flipped means write is one lap ahead
   localparam ptr_t FULL_MASK = ptr_t'(3) << (AW - 1);

   ptr_t wptr_b, wptr_g;       // Write side, wclk
   ptr_t rptr_b, rptr_g;       // Read side, rclk
   ptr_t wptr_b_nxt, wptr_g_nxt;
   ptr_t rptr_b_nxt, rptr_g_nxt;

   ptr_t rptr_g_s [2];         // Read Gray into wclk
   ptr_t wptr_g_s [2];         // Write Gray into rclk

   rec_t mem [DEPTH];          // Storage, no reset

   logic wr_ok;
   logic rd_ok;

   assign wr_ok = push & ~full;
   assign rd_ok = pop & ~empty;

   // Write pointer advance
   assign wptr_b_nxt = wptr_b + ptr_t'(wr_ok);
   assign wptr_g_nxt = (wptr_b_nxt >> 1) ^ wptr_b_nxt;  // Binary to Gray

   always_ff @(posedge wclk or negedge wrst_n) begin
      if (!wrst_n) begin
         wptr_b <= '0;
         wptr_g <= '0;
      end else begin
         wptr_b <= wptr_b_nxt;
         wptr_g <= wptr_g_nxt;
      end
   end

   // Read pointer advance
   assign rptr_b_nxt = rptr_b + ptr_t'(rd_ok);
   assign rptr_g_nxt = (rptr_b_nxt >> 1) ^ rptr_b_nxt;

   always_ff @(posedge rclk or negedge rrst_n) begin
      if (!rrst_n) begin
         rptr_b <= '0;
         rptr_g <= '0;
      end else begin
         rptr_b <= rptr_b_nxt;
         rptr_g <= rptr_g_nxt;
      end
   end

   // Two flop sync of read Gray pointer
   always_ff @(posedge wclk or negedge wrst_n) begin
      if (!wrst_n) begin
         rptr_g_s[0] <= '0;
         rptr_g_s[1] <= '0;
      end else begin
         rptr_g_s[0] <= rptr_g;
         rptr_g_s[1] <= rptr_g_s[0];
      end
   end

   // Two flop sync of write Gray pointer
   always_ff @(posedge rclk or negedge rrst_n) begin
      if (!rrst_n) begin
         wptr_g_s[0] <= '0;
         wptr_g_s[1] <= '0;
      end else begin
         wptr_g_s[0] <= wptr_g;
         wptr_g_s[1] <= wptr_g_s[0];
      end
   end

   // Registered flags from next Gray pointer
   always_ff @(posedge wclk or negedge wrst_n) begin
      if (!wrst_n) full <= 1'b0;
      else full <= (wptr_g_nxt == (rptr_g_s[1] ^ FULL_MASK));
   end

   always_ff @(posedge rclk or negedge rrst_n) begin
      if (!rrst_n) empty <= 1'b1;
      else empty <= (rptr_g_nxt == wptr_g_s[1]);
   end

   // Write port
   always_ff @(posedge wclk) begin
      if (wr_ok) mem[wptr_b[AW-1:0]] <= din;
   end

   // Registered read port, moves only on an accepted pop
   always_ff @(posedge rclk) begin
      if (rd_ok) dout <= mem[rptr_b[AW-1:0]];
   end

endmodule

//--- logic/drain_unit.sv
`timescale 1ns/1ps

module drain_unit import trace_pkg::*; (
   input  logic  rclk,
   input  logic  rrst_n,
   input  logic  rd_en,       // Consumer level, pops while high
   input  logic  empty,       // Registered FIFO empty
   input  rec_t  dout,        // Registered FIFO read word
   output logic  pop,
   output logic  rec_valid,
   output src_t  rec_src,
   output seq_t  rec_seq,
   output data_t rec_data
);

   // Pop only what is there
   assign pop = rd_en & ~empty;

   // dout updates on the pop edge
   // so the fields line up with the delayed pop
   always_ff @(posedge rclk or negedge rrst_n) begin
      if (!rrst_n) rec_valid <= 1'b0;
      else rec_valid <= pop;  // Single cycle per record
   end

   // Unpack in record order, src on top
   assign rec_src  = dout[$bits(rec_t)-1 -: $bits(src_t)];
   assign rec_seq  = dout[$bits(data_t) +: $bits(seq_t)];
   assign rec_data = dout[$bits(data_t)-1:0];

endmodule

//--- logic/push_arbiter.sv
`timescale 1ns/1ps

module push_arbiter import trace_pkg::*; (
   input  logic wclk,
   input  logic wrst_n,
   input  logic pend0,
   input  logic pend1,
   input  rec_t rec0,
   input  rec_t rec1,
   input  logic full,         // FIFO full, registered in wclk
   output logic grant0,
   output logic grant1,
   output logic push,
   output rec_t din
);

   grant_e last_gnt;          // Winner of the previous grant
   logic   pick1;             // Channel 1 wins this cycle

   // Ch1 wins alone, or on a tie when ch0 went last
   assign pick1 = pend1 & (~pend0 | (last_gnt == GNT_CH0));

   // One grant at most, and none while full
   assign grant0 = ~full & pend0 & ~pick1;
   assign grant1 = ~full & pick1;

   assign push = grant0 | grant1;

   // Data mux follows the pick, push qualifies it
   assign din = pick1 ? rec1 : rec0;

   // Round robin history
   // Starts on ch1 so ch0 takes the first tie
   always_ff @(posedge wclk or negedge wrst_n) begin
      if (!wrst_n) begin
         last_gnt <= GNT_CH1;
      end else if (grant0) begin
         last_gnt <= GNT_CH0;
      end else if (grant1) begin
         last_gnt <= GNT_CH1;
      end
   end

endmodule

//--- logic/trace_channel.sv
`timescale 1ns/1ps

module trace_channel import trace_pkg::*; #(
   parameter src_t chan_id = 1'b0      // Goes into the src field
) (
   input  logic  wclk,
   input  logic  wrst_n,
   input  logic  evt,                  // One cycle event strobe
   input  data_t event_data,
   input  logic  grant,                // From arbiter, only while pend
   output logic  pend,
   output rec_t  pend_rec,
   output logic  drop
);

   seq_t seq_cnt;                      // Next sequence number to hand out
   logic accept;
   logic reject;

   // Slot is free, or frees up on this same edge
   assign accept = evt & (~pend | grant);

   // Busy slot and no grant means the new event is lost
   assign reject = evt & pend & ~grant;

   // Pending flag and sequence count
   always_ff @(posedge wclk or negedge wrst_n) begin
      if (!wrst_n) begin
         pend    <= 1'b0;
         seq_cnt <= '0;
      end else begin
         if (accept) begin
            pend    <= 1'b1;
            seq_cnt <= seq_cnt + seq_t'(1);  // Dropped events skip this
         end else if (grant) begin
            pend    <= 1'b0;                 // Record handed to FIFO
         end
      end
   end

   // Drop strobe, one cycle after the lost event
   always_ff @(posedge wclk or negedge wrst_n) begin
      if (!wrst_n) drop <= 1'b0;
      else drop <= reject;
   end

   // Record payload
   // Held as is while pending, a drop leaves it alone
   always_ff @(posedge wclk) begin
      if (accept) begin
         pend_rec <= {chan_id, seq_cnt, event_data};
      end
   end

endmodule

//--- logic/trace_config.svh
`ifndef TRACE_CONFIG_SVH
`define TRACE_CONFIG_SVH

// FIFO address bits
// Depth is 1 << TRACE_AW entries
// Values of 2 and up keep the full compare valid
`define TRACE_AW 3

// Event data byte width
// Record width follows from this plus src and seq
`define TRACE_DW 8

// Sequence counter width per channel
// Wraps at 1 << TRACE_SW
`define TRACE_SW 4

`endif

//--- logic/trace_pkg.sv
`include "trace_config.svh"

package trace_pkg;

   // Channel index, two channels only
   typedef logic [0:0] src_t;

   // Per channel sequence number
   typedef logic [`TRACE_SW-1:0] seq_t;

   // Event payload
   typedef logic [`TRACE_DW-1:0] data_t;

   // Packed record with src on top, then seq, then data
   typedef logic [$bits(src_t)+$bits(seq_t)+`TRACE_DW-1:0] rec_t;

   // FIFO pointer with wrap bit
   typedef logic [`TRACE_AW:0] ptr_t;

   // Last channel granted by the push arbiter
   typedef enum logic {GNT_CH0, GNT_CH1} grant_e;

endpackage

//--- logic/trace_xdomain_top.sv
`timescale 1ns/1ps

module trace_xdomain_top import trace_pkg::*; (
   input  logic  wclk,
   input  logic  wrst_n,
   input  logic  rclk,
   input  logic  rrst_n,
   input  logic  ev0,
   input  logic  ev1,
   input  data_t ev0_data,
   input  data_t ev1_data,
   output logic  drop0,
   output logic  drop1,
   input  logic  rd_en,
   output logic  rec_valid,
   output src_t  rec_src,
   output seq_t  rec_seq,
   output data_t rec_data
);

   // Channel to arbiter
   logic pend0, pend1;
   rec_t pend_rec0, pend_rec1;
   logic grant0, grant1;

   // FIFO ports
   logic push;
   logic pop;
   logic full;
   logic empty;
   rec_t fifo_din;
   rec_t fifo_dout;

   // Write domain sources
   trace_channel #(.chan_id(1'b0)) u_ch0 (
      .wclk       (wclk),
      .wrst_n     (wrst_n),
      .evt        (ev0),
      .event_data (ev0_data),
      .grant      (grant0),
      .pend       (pend0),
      .pend_rec   (pend_rec0),
      .drop       (drop0)
   );

   trace_channel #(.chan_id(1'b1)) u_ch1 (
      .wclk       (wclk),
      .wrst_n     (wrst_n),
      .evt        (ev1),
      .event_data (ev1_data),
      .grant      (grant1),
      .pend       (pend1),
      .pend_rec   (pend_rec1),
      .drop       (drop1)
   );

   // Shared write port
   push_arbiter u_arb (
      .wclk   (wclk),
      .wrst_n (wrst_n),
      .pend0  (pend0),
      .pend1  (pend1),
      .rec0   (pend_rec0),
      .rec1   (pend_rec1),
      .full   (full),
      .grant0 (grant0),
      .grant1 (grant1),
      .push   (push),
      .din    (fifo_din)
   );

   // Clock crossing
   async_fifo u_fifo (
      .wclk   (wclk),
      .wrst_n (wrst_n),
      .rclk   (rclk),
      .rrst_n (rrst_n),
      .din    (fifo_din),
      .push   (push),
      .pop    (pop),
      .dout   (fifo_dout),
      .full   (full),
      .empty  (empty)
   );

   // Read domain output
   drain_unit u_drain (
      .rclk      (rclk),
      .rrst_n    (rrst_n),
      .rd_en     (rd_en),
      .empty     (empty),
      .dout      (fifo_dout),
      .pop       (pop),
      .rec_valid (rec_valid),
      .rec_src   (rec_src),
      .rec_seq   (rec_seq),
      .rec_data  (rec_data)
   );

endmodule

//--- sources.f
+incdir+logic
logic/trace_pkg.sv
logic/async_fifo.sv
logic/trace_channel.sv
logic/push_arbiter.sv
logic/drain_unit.sv
logic/trace_xdomain_top.sv
tb/trace_asserts.sv
tb/trace_tb.sv

//--- tb/trace_asserts.sv
`timescale 1ns/1ps

module trace_asserts (
   input logic wclk,
   input logic wrst_n,
   input logic rclk,
   input logic rrst_n,
   input logic ev0,
   input logic ev1,
   input logic drop0,
   input logic drop1,
   input logic push,
   input logic full,
   input logic grant0,
   input logic grant1,
   input logic pop,
   input logic rec_valid
);

   // Arbiter holds off on a full FIFO
   no_push_when_full: assert property (@(posedge wclk) disable iff (!wrst_n)
      !(push && full)) else $error("push while FIFO full");

   one_grant_max: assert property (@(posedge wclk) disable iff (!wrst_n)
      !(grant0 && grant1)) else $error("both channels granted");

   // Drop strobe trails the lost event by one cycle
   drop0_after_event: assert property (@(posedge wclk) disable iff (!wrst_n)
      drop0 |-> $past(ev0)) else $error("drop0 without event");

   drop1_after_event: assert property (@(posedge wclk) disable iff (!wrst_n)
      drop1 |-> $past(ev1)) else $error("drop1 without event");

   valid_after_pop: assert property (@(posedge rclk) disable iff (!rrst_n)
      rec_valid |-> $past(pop)) else $error("rec_valid without pop");

endmodule

bind trace_xdomain_top trace_asserts u_asserts (
   .wclk(wclk), .wrst_n(wrst_n), .rclk(rclk), .rrst_n(rrst_n),
   .ev0(ev0), .ev1(ev1), .drop0(drop0), .drop1(drop1),
   .push(push), .full(full), .grant0(grant0), .grant1(grant1),
   .pop(pop), .rec_valid(rec_valid)
);

//--- tb/trace_tb.sv
`timescale 1ns/1ps

module trace_tb import trace_pkg::*; ();

   localparam int RCLK_PERIOD = 100;
   localparam int WCLK_PERIOD = 70;   // Unrelated to rclk, edges never meet
   localparam int N_SINGLE    = 40;   // Enough to wrap seq twice
   localparam int N_BOTH      = 32;
   localparam int N_BURST     = 8;    // Back to back on both channels
   localparam int BP_CYC      = 200;
   localparam int RAND_CYC    = 300;
   localparam int TOTAL_EV    = N_SINGLE + 2 * N_BOTH + 2 * N_BURST + 2 * BP_CYC
                                + 2 * RAND_CYC;
   localparam int WATCHDOG_NS = TOTAL_EV * 20 * WCLK_PERIOD + 20000;

   logic  wclk, wrst_n, rclk, rrst_n;
   logic  ev0, ev1, rd_en;
   data_t ev0_data, ev1_data;
   logic  drop0, drop1, rec_valid;
   src_t  rec_src;
   seq_t  rec_seq;
   data_t rec_data;

   logic [31:0] wseed = 32'd40806;    // Write side stimulus
   logic [31:0] rseed = 32'd40806;    // Read side rd_en
   int   rd_mode = 1;                 // 0 low, 1 high, 2 random

   rec_t  exp_q0 [$];                 // Expected records per channel
   rec_t  exp_q1 [$];
   seq_t  ref_seq [2]   = '{default: '0};
   seq_t  rx_seq [2]    = '{default: '0};
   int    rx_cnt [2]    = '{default: 0};
   int    drop_cnt [2]  = '{default: 0};
   int    drv_cnt [2]   = '{default: 0};
   logic  last_ev [2]   = '{default: 1'b0};
   data_t last_data [2] = '{default: '0};
   rec_t  got_rec, exp_rec;

   trace_xdomain_top trace_xdomain_top_inst (
      .wclk(wclk), .wrst_n(wrst_n), .rclk(rclk), .rrst_n(rrst_n),
      .ev0(ev0), .ev1(ev1), .ev0_data(ev0_data), .ev1_data(ev1_data),
      .drop0(drop0), .drop1(drop1), .rd_en(rd_en),
      .rec_valid(rec_valid), .rec_src(rec_src), .rec_seq(rec_seq), .rec_data(rec_data)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      lcg_next = s * 32'd1103515245 + 32'd12345;
   endfunction

   // Record layout is src on top, then seq, then data
   function automatic rec_t ref_record(input src_t ch, input seq_t seq, input data_t data);
      ref_record = {ch, seq, data};
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped on first failure");
   endtask

   task automatic check_value(input string what, input int got, input int exp);
      if (got != exp) begin
         abort_run($sformatf("[ERROR] %0t: %s got 0x%0h expected 0x%0h",
                             $time, what, got, exp));
      end
   endtask

   initial begin
      wclk = 1'b0;
      forever #(WCLK_PERIOD / 2) wclk = ~wclk;
   end

   initial begin
      rclk = 1'b0;
      forever #(RCLK_PERIOD / 2) rclk = ~rclk;
   end

   // Each reset held 10 cycles of its own clock
   initial begin
      wrst_n = 1'b0;
      repeat (10) @(posedge wclk);
      #5 wrst_n = 1'b1;
   end

   initial begin
      rrst_n = 1'b0;
      repeat (10) @(posedge rclk);
      #5 rrst_n = 1'b1;
   end

   initial begin
      #(WATCHDOG_NS);
      abort_run("Watchdog timeout, the test did not finish in time");
   end

   // rd_en driver in rclk domain
   initial begin
      rd_en = 1'b0;
      forever begin
         @(posedge rclk);
         #5;
         rseed = lcg_next(rseed);
         case (rd_mode)
            0:       rd_en = 1'b0;
            1:       rd_en = 1'b1;
            default: rd_en = rseed[27];
         endcase
      end
   end

   // Event monitor, drop shows one edge after the event
   always @(posedge wclk) begin
      if (wrst_n && last_ev[0]) begin
         if (drop0) drop_cnt[0]++;
         else begin
            exp_q0.push_back(ref_record(1'b0, ref_seq[0], last_data[0]));
            ref_seq[0] = ref_seq[0] + seq_t'(1);   // Only kept events count
         end
      end
      if (wrst_n && last_ev[1]) begin
         if (drop1) drop_cnt[1]++;
         else begin
            exp_q1.push_back(ref_record(1'b1, ref_seq[1], last_data[1]));
            ref_seq[1] = ref_seq[1] + seq_t'(1);
         end
      end
      last_ev[0]   = ev0 & wrst_n;
      last_ev[1]   = ev1 & wrst_n;
      last_data[0] = ev0_data;
      last_data[1] = ev1_data;
   end

   // Compare on each output record
   always @(posedge rclk) begin
      if (rrst_n && rec_valid) begin
         got_rec = {rec_src, rec_seq, rec_data};
         if (rec_src == 1'b0 && exp_q0.size() == 0) begin
            abort_run("Record on channel 0 with nothing outstanding");
         end else if (rec_src == 1'b1 && exp_q1.size() == 0) begin
            abort_run("Record on channel 1 with nothing outstanding");
         end else begin
            exp_rec = (rec_src == 1'b0) ? exp_q0.pop_front() : exp_q1.pop_front();
            check_value("sequence step", int'(rec_seq), int'(rx_seq[rec_src]));
            check_value("record", int'(got_rec), int'(exp_rec));
            rx_seq[rec_src] = rec_seq + seq_t'(1);
            rx_cnt[rec_src]++;
         end
      end
   end

   task automatic drive_cycle(input logic e0, input logic e1);
      @(posedge wclk);
      #5;
      wseed    = lcg_next(wseed);
      ev0      = e0;
      ev1      = e1;
      ev0_data = data_t'(wseed >> 16);
      ev1_data = data_t'(wseed >> 8);
      if (e0) drv_cnt[0]++;
      if (e1) drv_cnt[1]++;
   endtask

   task automatic random_cycle();
      wseed = lcg_next(wseed);
      drive_cycle(wseed[30], wseed[29]);
   endtask

   // Idle, read on, wait for both queues to empty
   task automatic wait_drained();
      repeat (4) drive_cycle(1'b0, 1'b0);
      rd_mode = 1;
      while (exp_q0.size() != 0 || exp_q1.size() != 0) @(posedge rclk);
      repeat (6) @(posedge rclk);
   endtask

   task automatic run_backpressure();
      int drops_at_start;
      int n;
      rd_mode = 0;
      repeat (3) @(posedge rclk);
      drops_at_start = drop_cnt[0] + drop_cnt[1];
      n = 0;
      while (drop_cnt[0] + drop_cnt[1] == drops_at_start && n < BP_CYC) begin
         random_cycle();
         n++;
      end
      if (drop_cnt[0] + drop_cnt[1] == drops_at_start) begin
         abort_run("No drop seen while reads were held off");
      end else begin
         repeat (20) random_cycle();   // Keep pressure a while
         wait_drained();
      end
   endtask

   initial begin
      int rx0, rx1, dr0, dr1;
      ev0      = 1'b0;
      ev1      = 1'b0;
      ev0_data = '0;
      ev1_data = '0;
      wait (wrst_n && rrst_n);
      check_value("rec_valid after reset", int'(rec_valid), 0);
      check_value("drop0 after reset", int'(drop0), 0);
      check_value("drop1 after reset", int'(drop1), 0);
      repeat (20) begin
         @(posedge rclk);
         check_value("rec_valid while idle", int'(rec_valid), 0);
      end

      // Channel 0 only, spaced apart
      for (int i = 0; i < N_SINGLE; i++) begin
         drive_cycle(1'b1, 1'b0);
         repeat (3) drive_cycle(1'b0, 1'b0);
      end
      wait_drained();
      check_value("channel 0 records", rx_cnt[0], N_SINGLE);
      check_value("channel 1 records", rx_cnt[1], 0);

      // Both channels in the same cycles
      rx0 = rx_cnt[0];
      rx1 = rx_cnt[1];
      dr0 = drop_cnt[0];
      dr1 = drop_cnt[1];
      for (int i = 0; i < N_BOTH; i++) begin
         drive_cycle(1'b1, 1'b1);
         repeat (3) drive_cycle(1'b0, 1'b0);
      end
      wait_drained();
      check_value("channel 0 share", rx_cnt[0] - rx0, N_BOTH);
      check_value("channel 1 share", rx_cnt[1] - rx1, N_BOTH);
      check_value("drops with both", drop_cnt[0] + drop_cnt[1] - dr0 - dr1, 0);

      // Back to back on both, grants alternate so drops split evenly
      dr0 = drop_cnt[0];
      dr1 = drop_cnt[1];
      repeat (N_BURST) drive_cycle(1'b1, 1'b1);
      wait_drained();
      dr0 = drop_cnt[0] - dr0;
      dr1 = drop_cnt[1] - dr1;
      check_value("burst drop split within one", int'(dr0 - dr1 <= 1 && dr1 - dr0 <= 1), 1);

      run_backpressure();

      // Random traffic and random reads
      rd_mode = 2;
      repeat (RAND_CYC) random_cycle();
      wait_drained();

      check_value("channel 0 queue left", exp_q0.size(), 0);
      check_value("channel 1 queue left", exp_q1.size(), 0);
      check_value("channel 0 records plus drops", rx_cnt[0] + drop_cnt[0], drv_cnt[0]);
      check_value("channel 1 records plus drops", rx_cnt[1] + drop_cnt[1], drv_cnt[1]);
      $display("RESULT: PASS");
      $finish;
   end

endmodule
